/* common/axis_pkg.sv */
/*
 * Stream field definitions shared by the stream interface, the merger
 * top level and the testbench. tuser is a one-bit error flag that the
 * design carries through without looking at it.
 */

`default_nettype none

package axis_pkg;

    // tuser carries a single error flag per beat
    localparam int USER_WIDTH = 1;

    typedef logic [USER_WIDTH-1:0] user_t;

endpackage

`default_nettype wire

/* common/mux_pkg.sv */
/*
 * Frame multiplexer definitions: number of merged inputs, the port
 * index type (also used as tdest on the output) and the arbiter state.
 */

`default_nettype none

package mux_pkg;

    localparam int NUM_PORTS = 2;

    // source port index, doubles as the tdest field
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // idle until a frame starts, busy until its tlast beat transfers
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

/* common/axis_if.sv */
/*
 * Stream link between blocks inside the merger. The source side drives
 * everything except tready, the sink side drives tready. A beat moves on
 * a clock edge where tvalid and tready are both high.
 */

`timescale 1ns/1ps
`default_nettype none

interface axis_if #(
    parameter int DATA_WIDTH = 8
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    axis_pkg::user_t       tuser;
    mux_pkg::port_idx_t    tdest;

    modport source (
        output tdata, tkeep, tvalid, tlast, tuser, tdest,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser, tdest,
        output tready
    );

endinterface

`default_nettype wire

/* hw/axis_register/axis_register.sv */
/*
 * Stream register slice. REG_TYPE selects the structure: 0 is plain
 * wiring, 1 is a single output register that accepts every other cycle,
 * 2 is a skid buffer that runs at full rate with a registered tready.
 */

`timescale 1ns/1ps
`default_nettype none

module axis_register #(
    parameter int DATA_WIDTH = 8,
    parameter int REG_TYPE   = 2
) (
    input  logic   clk,
    input  logic   rst,
    axis_if.sink   s,
    axis_if.source m
);

    localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
    localparam int PAYLOAD_WIDTH = DATA_WIDTH + KEEP_WIDTH + 1 + axis_pkg::USER_WIDTH
                                   + $bits(mux_pkg::port_idx_t);

    // all beat fields packed together so each stage moves one vector
    logic [PAYLOAD_WIDTH-1:0] s_payload;
    logic [PAYLOAD_WIDTH-1:0] m_payload;

    assign s_payload = {s.tdata, s.tkeep, s.tlast, s.tuser, s.tdest};
    assign {m.tdata, m.tkeep, m.tlast, m.tuser, m.tdest} = m_payload;

    generate
        if (REG_TYPE > 1) begin : g_skid
            logic                     s_ready_reg;
            logic                     s_ready_early;
            logic                     m_valid_reg;
            logic                     m_valid_next;
            logic                     tmp_valid_reg;
            logic                     tmp_valid_next;
            logic [PAYLOAD_WIDTH-1:0] m_payload_reg;
            logic [PAYLOAD_WIDTH-1:0] tmp_payload_reg;
            logic                     load_out_from_in;
            logic                     load_tmp_from_in;
            logic                     load_out_from_tmp;

            // keep accepting unless the temp register could fill up
            assign s_ready_early = m.tready
                                   || (!tmp_valid_reg && (!m_valid_reg || !s.tvalid));

            assign s.tready  = s_ready_reg;
            assign m.tvalid  = m_valid_reg;
            assign m_payload = m_payload_reg;

            always_comb begin
                m_valid_next      = m_valid_reg;
                tmp_valid_next    = tmp_valid_reg;
                load_out_from_in  = 1'b0;
                load_tmp_from_in  = 1'b0;
                load_out_from_tmp = 1'b0;

                if (s_ready_reg) begin
                    if (m.tready || !m_valid_reg) begin
                        // output free, input goes straight there
                        m_valid_next     = s.tvalid;
                        load_out_from_in = 1'b1;
                    end else begin
                        // output stalled, park the beat
                        tmp_valid_next   = s.tvalid;
                        load_tmp_from_in = 1'b1;
                    end
                end else if (m.tready) begin
                    // drain the parked beat
                    m_valid_next      = tmp_valid_reg;
                    tmp_valid_next    = 1'b0;
                    load_out_from_tmp = 1'b1;
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    s_ready_reg   <= 1'b0;
                    m_valid_reg   <= 1'b0;
                    tmp_valid_reg <= 1'b0;
                end else begin
                    s_ready_reg   <= s_ready_early;
                    m_valid_reg   <= m_valid_next;
                    tmp_valid_reg <= tmp_valid_next;
                end
            end

            always_ff @(posedge clk) begin
                if (load_out_from_in) begin
                    m_payload_reg <= s_payload;
                end else if (load_out_from_tmp) begin
                    m_payload_reg <= tmp_payload_reg;
                end
                if (load_tmp_from_in) begin
                    tmp_payload_reg <= s_payload;
                end
            end
        end else if (REG_TYPE == 1) begin : g_simple
            logic                     s_ready_reg;
            logic                     m_valid_reg;
            logic                     m_valid_next;
            logic [PAYLOAD_WIDTH-1:0] m_payload_reg;
            logic                     load_out_from_in;

            assign s.tready  = s_ready_reg;
            assign m.tvalid  = m_valid_reg;
            assign m_payload = m_payload_reg;

            always_comb begin
                m_valid_next     = m_valid_reg;
                load_out_from_in = 1'b0;

                if (s_ready_reg) begin
                    m_valid_next     = s.tvalid;
                    load_out_from_in = 1'b1;
                end else if (m.tready) begin
                    m_valid_next = 1'b0;
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    s_ready_reg <= 1'b0;
                    m_valid_reg <= 1'b0;
                end else begin
                    // ready only when the register will be empty
                    s_ready_reg <= !m_valid_next;
                    m_valid_reg <= m_valid_next;
                end
            end

            always_ff @(posedge clk) begin
                if (load_out_from_in) begin
                    m_payload_reg <= s_payload;
                end
            end
        end else begin : g_bypass
            assign m_payload = s_payload;
            assign m.tvalid  = s.tvalid;
            assign s.tready  = m.tready;
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/axis_frame_mux/axis_frame_mux.sv */
/*
 * Two-to-one frame multiplexer. Picks a port round-robin only between
 * frames, holds the grant until the tlast beat has transferred and
 * writes the source port number into tdest. The data path is purely
 * combinational from the granted input to the output.
 */

`timescale 1ns/1ps
`default_nettype none

module axis_frame_mux #(
    parameter int DATA_WIDTH = 8
) (
    input  logic   clk,
    input  logic   rst,
    axis_if.sink   s0,
    axis_if.sink   s1,
    axis_if.source m
);

    mux_pkg::arb_state_t            state;
    mux_pkg::port_idx_t             grant;
    mux_pkg::port_idx_t             last_grant;
    mux_pkg::port_idx_t             rr_next;
    mux_pkg::port_idx_t             rr_other;
    mux_pkg::port_idx_t             pick;
    mux_pkg::port_idx_t             active;
    logic [mux_pkg::NUM_PORTS-1:0]  in_valid;
    logic                           beat_done;

    assign in_valid = {s1.tvalid, s0.tvalid};

    // port after the one served last gets priority
    assign rr_next  = (last_grant == mux_pkg::port_idx_t'(mux_pkg::NUM_PORTS - 1))
                      ? '0 : last_grant + 1'b1;
    assign rr_other = (rr_next == mux_pkg::port_idx_t'(mux_pkg::NUM_PORTS - 1))
                      ? '0 : rr_next + 1'b1;

    always_comb begin
        if (in_valid[rr_next]) begin
            pick = rr_next;
        end else if (in_valid[rr_other]) begin
            pick = rr_other;
        end else begin
            pick = rr_next;
        end
    end

    // grant is held for the whole frame once it has started
    assign active = (state == mux_pkg::ARB_BUSY) ? grant : pick;

    // output lane select
    always_comb begin
        if (active == '0) begin
            m.tdata  = s0.tdata;
            m.tkeep  = s0.tkeep;
            m.tvalid = s0.tvalid;
            m.tlast  = s0.tlast;
            m.tuser  = s0.tuser;
        end else begin
            m.tdata  = s1.tdata;
            m.tkeep  = s1.tkeep;
            m.tvalid = s1.tvalid;
            m.tlast  = s1.tlast;
            m.tuser  = s1.tuser;
        end
    end

    assign m.tdest = active;

    // only the granted lane sees the output ready
    assign s0.tready = (active == '0) && m.tready;
    assign s1.tready = (active != '0) && m.tready;

    assign beat_done = m.tvalid && m.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= mux_pkg::ARB_IDLE;
            grant      <= '0;
            last_grant <= mux_pkg::port_idx_t'(mux_pkg::NUM_PORTS - 1);
        end else if (beat_done) begin
            grant <= active;
            if (m.tlast) begin
                // frame finished, reopen arbitration
                state      <= mux_pkg::ARB_IDLE;
                last_grant <= active;
            end else begin
                state <= mux_pkg::ARB_BUSY;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/axis_merge_top.sv */
/*
 * Two-port stream frame merger. Each input goes through its own register
 * slice, the frame multiplexer joins the two lanes and an output slice
 * buffers the merged stream. m_axis_tdest names the source port.
 */

`timescale 1ns/1ps
`default_nettype none

module axis_merge_top #(
    parameter int DATA_WIDTH   = 8,
    parameter int IN_REG_TYPE  = 2,
    parameter int OUT_REG_TYPE = 2
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [DATA_WIDTH-1:0]       s0_axis_tdata,
    input  logic [DATA_WIDTH/8-1:0]     s0_axis_tkeep,
    input  logic                        s0_axis_tvalid,
    output logic                        s0_axis_tready,
    input  logic                        s0_axis_tlast,
    input  axis_pkg::user_t             s0_axis_tuser,

    input  logic [DATA_WIDTH-1:0]       s1_axis_tdata,
    input  logic [DATA_WIDTH/8-1:0]     s1_axis_tkeep,
    input  logic                        s1_axis_tvalid,
    output logic                        s1_axis_tready,
    input  logic                        s1_axis_tlast,
    input  axis_pkg::user_t             s1_axis_tuser,

    output logic [DATA_WIDTH-1:0]       m_axis_tdata,
    output logic [DATA_WIDTH/8-1:0]     m_axis_tkeep,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output logic                        m_axis_tlast,
    output axis_pkg::user_t             m_axis_tuser,
    output mux_pkg::port_idx_t          m_axis_tdest
);

    axis_if #(.DATA_WIDTH(DATA_WIDTH)) s0_in ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) s1_in ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) in0_reg ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) in1_reg ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) mux_out ();
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) m_out ();

    // input ports onto links, tdest set to the port number
    assign s0_in.tdata    = s0_axis_tdata;
    assign s0_in.tkeep    = s0_axis_tkeep;
    assign s0_in.tvalid   = s0_axis_tvalid;
    assign s0_in.tlast    = s0_axis_tlast;
    assign s0_in.tuser    = s0_axis_tuser;
    assign s0_in.tdest    = mux_pkg::port_idx_t'(0);
    assign s0_axis_tready = s0_in.tready;

    assign s1_in.tdata    = s1_axis_tdata;
    assign s1_in.tkeep    = s1_axis_tkeep;
    assign s1_in.tvalid   = s1_axis_tvalid;
    assign s1_in.tlast    = s1_axis_tlast;
    assign s1_in.tuser    = s1_axis_tuser;
    assign s1_in.tdest    = mux_pkg::port_idx_t'(1);
    assign s1_axis_tready = s1_in.tready;

    axis_register #(
        .DATA_WIDTH(DATA_WIDTH),
        .REG_TYPE  (IN_REG_TYPE)
    ) in0_slice (
        .clk(clk),
        .rst(rst),
        .s  (s0_in),
        .m  (in0_reg)
    );

    axis_register #(
        .DATA_WIDTH(DATA_WIDTH),
        .REG_TYPE  (IN_REG_TYPE)
    ) in1_slice (
        .clk(clk),
        .rst(rst),
        .s  (s1_in),
        .m  (in1_reg)
    );

    axis_frame_mux #(
        .DATA_WIDTH(DATA_WIDTH)
    ) frame_mux (
        .clk(clk),
        .rst(rst),
        .s0 (in0_reg),
        .s1 (in1_reg),
        .m  (mux_out)
    );

    axis_register #(
        .DATA_WIDTH(DATA_WIDTH),
        .REG_TYPE  (OUT_REG_TYPE)
    ) out_slice (
        .clk(clk),
        .rst(rst),
        .s  (mux_out),
        .m  (m_out)
    );

    // merged link back to plain output ports
    assign m_axis_tdata  = m_out.tdata;
    assign m_axis_tkeep  = m_out.tkeep;
    assign m_axis_tvalid = m_out.tvalid;
    assign m_axis_tlast  = m_out.tlast;
    assign m_axis_tuser  = m_out.tuser;
    assign m_axis_tdest  = m_out.tdest;
    assign m_out.tready  = m_axis_tready;

endmodule

`default_nettype wire

/* verification/tb_axis_merge.sv */
/*
 * Directed testbench for the two-port stream merger. Frame drivers feed
 * both inputs, a monitor matches every output beat against per-source
 * queues picked by tdest and records the port of each output frame.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axis_merge;

    localparam int DATA_WIDTH = 8;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        axis_pkg::user_t       user;
    } beat_t;

    function automatic int frame_len(input int k, input int base, input int step);
        return base + (k * step) % 5;
    endfunction

    function automatic int count_beats(input int n, input int base, input int step);
        int sum;
        sum = 0;
        for (int k = 0; k < n; k++) begin
            sum += frame_len(k, base, step);
        end
        return sum;
    endfunction

    // frame sets of the five traffic tests, sent on both ports
    localparam int TOTAL_BEATS = 2 * (count_beats(3, 1, 2) + count_beats(4, 2, 3)
                                 + count_beats(6, 3, 0) + count_beats(5, 4, 0)
                                 + count_beats(8, 1, 0));
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] s0_axis_tdata;
    logic [KEEP_WIDTH-1:0] s0_axis_tkeep;
    logic                  s0_axis_tvalid;
    logic                  s0_axis_tready;
    logic                  s0_axis_tlast;
    axis_pkg::user_t       s0_axis_tuser;
    logic [DATA_WIDTH-1:0] s1_axis_tdata;
    logic [KEEP_WIDTH-1:0] s1_axis_tkeep;
    logic                  s1_axis_tvalid;
    logic                  s1_axis_tready;
    logic                  s1_axis_tlast;
    axis_pkg::user_t       s1_axis_tuser;
    logic [DATA_WIDTH-1:0] m_axis_tdata;
    logic [KEEP_WIDTH-1:0] m_axis_tkeep;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;
    logic                  m_axis_tlast;
    axis_pkg::user_t       m_axis_tuser;
    mux_pkg::port_idx_t    m_axis_tdest;

    beat_t                 out_beat;
    beat_t                 held_beat;
    beat_t                 exp0[$];
    beat_t                 exp1[$];
    mux_pkg::port_idx_t    frame_dest_q[$];
    mux_pkg::port_idx_t    held_dest;
    mux_pkg::port_idx_t    cur_dest;
    logic                  throttle;
    logic                  stall_now;
    logic                  stalled;
    logic                  in_frame;
    int                    mismatches;
    int                    faults;
    int                    cycle_count;

    axis_merge_top UUT (.*);

    assign out_beat = {m_axis_tdata, m_axis_tkeep, m_axis_tlast, m_axis_tuser};

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // random output stall while throttling, otherwise always ready
    always @(posedge clk) begin
        stall_now = throttle && ($urandom % 2 == 0);
        #1;
        m_axis_tready = !stall_now;
    end

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_keep(input string name, input logic [KEEP_WIDTH-1:0] got,
                              input logic [KEEP_WIDTH-1:0] want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_user(input string name, input axis_pkg::user_t got,
                              input axis_pkg::user_t want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_port(input string name, input mux_pkg::port_idx_t got,
                              input mux_pkg::port_idx_t want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic compare_beat(input beat_t got, input beat_t want);
        check_data("m_axis_tdata", got.data, want.data);
        check_keep("m_axis_tkeep", got.keep, want.keep);
        check_bit("m_axis_tlast", got.last, want.last);
        check_user("m_axis_tuser", got.user, want.user);
    endtask

    task automatic take_output_beat();
        beat_t want;
        if (m_axis_tdest == 1'b0 && exp0.size() > 0) begin
            want = exp0.pop_front();
        end else if (m_axis_tdest == 1'b1 && exp1.size() > 0) begin
            want = exp1.pop_front();
        end else begin
            faults++;
            $display("t=%0t: output beat for port %0d has no pending input beat",
                     $time, m_axis_tdest);
            return;
        end
        compare_beat(out_beat, want);
        if (in_frame) begin
            check_port("m_axis_tdest within frame", m_axis_tdest, cur_dest);
        end else begin
            frame_dest_q.push_back(m_axis_tdest);
            cur_dest = m_axis_tdest;
        end
        in_frame = !m_axis_tlast;
    endtask

    // mid-cycle sampling, all outputs and tready settled here
    always @(negedge clk) begin
        if (m_axis_tvalid && stalled) begin
            compare_beat(out_beat, held_beat);
            check_port("m_axis_tdest while stalled", m_axis_tdest, held_dest);
        end else if (stalled) begin
            faults++;
            $display("t=%0t: m_axis_tvalid dropped before its beat was accepted", $time);
        end
        stalled   = m_axis_tvalid && !m_axis_tready;
        held_beat = out_beat;
        held_dest = m_axis_tdest;
        if (m_axis_tvalid && m_axis_tready) begin
            take_output_beat();
        end
    end

    task automatic drive_lane(input mux_pkg::port_idx_t port, input beat_t b, input logic valid);
        if (port == 1'b0) begin
            {s0_axis_tdata, s0_axis_tkeep, s0_axis_tlast, s0_axis_tuser} = b;
            s0_axis_tvalid = valid;
        end else begin
            {s1_axis_tdata, s1_axis_tkeep, s1_axis_tlast, s1_axis_tuser} = b;
            s1_axis_tvalid = valid;
        end
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic send_frame(input mux_pkg::port_idx_t port, input int len,
                              input logic [DATA_WIDTH-1:0] seed);
        beat_t b;
        logic  taken;
        for (int i = 0; i < len; i++) begin
            b.data = seed + DATA_WIDTH'(i);
            b.keep = '1;
            b.last = (i == len - 1);
            b.user = axis_pkg::user_t'($urandom);
            drive_lane(port, b, 1'b1);
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = (port == 1'b0) ? s0_axis_tready : s1_axis_tready;
                @(posedge clk);
                #1;
            end
            if (port == 1'b0) begin
                exp0.push_back(b);
            end else begin
                exp1.push_back(b);
            end
        end
        drive_lane(port, b, 1'b0);
    endtask

    task automatic send_frames(input mux_pkg::port_idx_t port, input int n,
                               input int base, input int step);
        for (int k = 0; k < n; k++) begin
            send_frame(port, frame_len(k, base, step), DATA_WIDTH'($urandom));
        end
    endtask

    task automatic wait_drain();
        while (exp0.size() != 0 || exp1.size() != 0) begin
            @(posedge clk);
        end
        // a few more cycles so a duplicated beat would still show up
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic check_frame_order(input int frames, input mux_pkg::port_idx_t first,
                                     input logic alternate);
        mux_pkg::port_idx_t want;
        if (frame_dest_q.size() != frames) begin
            faults++;
            $display("t=%0t: expected %0d output frames but saw %0d",
                     $time, frames, frame_dest_q.size());
        end
        foreach (frame_dest_q[k]) begin
            want = alternate ? mux_pkg::port_idx_t'((k + int'(first)) % 2) : first;
            check_port("frame tdest", frame_dest_q[k], want);
        end
    endtask

    task automatic apply_reset(input logic check);
        logic ready;
        rst = 1'b1;
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            if (check && c > 0) begin
                check_bit("m_axis_tvalid in reset", m_axis_tvalid, 1'b0);
                check_bit("s0_axis_tready in reset", s0_axis_tready, 1'b0);
                check_bit("s1_axis_tready in reset", s1_axis_tready, 1'b0);
            end
            @(posedge clk);
        end
        #1;
        rst   = 1'b0;
        ready = 1'b0;
        for (int c = 0; c < 2 && !ready; c++) begin
            @(negedge clk);
            ready = s0_axis_tready && s1_axis_tready;
            if (check) begin
                check_bit("m_axis_tvalid after reset", m_axis_tvalid, 1'b0);
            end
            @(posedge clk);
            #1;
        end
        if (check && !ready) begin
            faults++;
            $display("t=%0t: input tready did not rise within two cycles of reset", $time);
        end
        frame_dest_q.delete();
    endtask

    task automatic test_single_port();
        apply_reset(1'b0);
        send_frames(1'b0, 3, 1, 2);
        wait_drain();
        check_frame_order(3, 1'b0, 1'b0);
        frame_dest_q.delete();
        send_frames(1'b1, 3, 1, 2);
        wait_drain();
        check_frame_order(3, 1'b1, 1'b0);
    endtask

    task automatic test_merge();
        apply_reset(1'b0);
        fork
            send_frames(1'b0, 4, 2, 3);
            begin
                repeat (2) @(posedge clk);
                #1;
                send_frames(1'b1, 4, 2, 3);
            end
        join
        wait_drain();
        if (frame_dest_q.size() != 8) begin
            faults++;
            $display("t=%0t: merged run produced %0d frames instead of 8",
                     $time, frame_dest_q.size());
        end
    endtask

    task automatic test_round_robin();
        apply_reset(1'b0);
        fork
            send_frames(1'b0, 6, 3, 0);
            send_frames(1'b1, 6, 3, 0);
        join
        wait_drain();
        check_frame_order(12, 1'b0, 1'b1);
    endtask

    task automatic test_backpressure();
        apply_reset(1'b0);
        throttle = 1'b1;
        fork
            send_frames(1'b0, 5, 4, 0);
            send_frames(1'b1, 5, 4, 0);
        join
        throttle = 1'b0;
        wait_drain();
    endtask

    task automatic test_single_beat();
        apply_reset(1'b0);
        fork
            send_frames(1'b0, 8, 1, 0);
            send_frames(1'b1, 8, 1, 0);
        join
        wait_drain();
        check_frame_order(16, 1'b0, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h6d2ed641));
        mismatches    = 0;
        faults        = 0;
        cycle_count   = 0;
        throttle      = 1'b0;
        stalled       = 1'b0;
        in_frame      = 1'b0;
        rst           = 1'b1;
        m_axis_tready = 1'b1;
        drive_lane(1'b0, '0, 1'b0);
        drive_lane(1'b1, '0, 1'b0);
        apply_reset(1'b1);
        test_single_port();
        test_merge();
        test_round_robin();
        test_backpressure();
        test_single_beat();
        $display("checks done with %0d value mismatches and %0d other failures",
                 mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/axis_pkg.sv
common/mux_pkg.sv
common/axis_if.sv
hw/axis_register/axis_register.sv
hw/axis_frame_mux/axis_frame_mux.sv
hw/axis_merge_top.sv
verification/tb_axis_merge.sv

/* run_sim.sh */
#!/bin/sh
# Builds the merger testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_axis_merge -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_axis_merge" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
